// File: common/peak_detector_config.svh
/* Preamble peak detector configuration.
   Stream widths, delay and preamble lengths, AGC level and settings address. */
`ifndef PEAK_DETECTOR_CONFIG_SVH
`define PEAK_DETECTOR_CONFIG_SVH

// Stream widths.
`define WIDTH_METRIC 16   // Unsigned delay-correlation metric.
`define WIDTH_PHASE  32   // Signed coarse phase.
`define WIDTH_MAG    16   // Unsigned magnitude.
`define WIDTH_SAMPLE 16   // Each of I and Q.

// Timing of the preamble search.
`define SAMPLE_DELAY 63   // Delay line length in samples.
`define PREAMBLE_LEN 16

// Target output level for the AGC.
`define AGC_REF_LEVEL 5000

// Settings bus addresses.
`define SR_THRESHOLD 5

`endif

// File: common/peak_detector_pkg.sv
/* Shared types of the preamble peak detector. */
package peak_detector_pkg;

  `include "peak_detector_config.svh"

  // Complex sample with I in the upper half.
  typedef struct packed {
    logic signed [`WIDTH_SAMPLE-1:0] i;
    logic signed [`WIDTH_SAMPLE-1:0] q;
  } sample_iq_t;

  // One sample word read as raw bits or as an I/Q pair.
  typedef union packed {
    logic [2*`WIDTH_SAMPLE-1:0] raw;
    sample_iq_t                 iq;
  } sample_word_t;

  // Search states of the peak FSM.
  typedef enum logic [1:0] {
    S_WAIT_THRESHOLD = 2'd0,
    S_TRACK_PEAK     = 2'd1,
    S_ALIGN_OUTPUT   = 2'd2
  } search_state_t;

endpackage

// File: logic/settings_reg.sv
/* Settings bus register holding the detection threshold. */
`timescale 1ns/1ps
`include "peak_detector_config.svh"

module settings_reg (
  input  logic        clk,
  input  logic        reset,
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  output logic [15:0] o_threshold
);

  logic addr_hit;

  assign addr_hit = (i_set_addr == 8'(`SR_THRESHOLD));

  always_ff @(posedge clk) begin
    if (reset) begin
      o_threshold <= '0;
    end else if (i_set_stb && addr_hit) begin
      o_threshold <= i_set_data[15:0];  // Only the low half is used.
    end
  end

endmodule

// File: logic/sample_delay_line.sv
/* Fixed sample delay line.
   A word leaves only once SAMPLE_DELAY newer words are stored behind it. */
`timescale 1ns/1ps
`include "peak_detector_config.svh"

module sample_delay_line
  import peak_detector_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  sample_word_t i_sample,
  input  logic         i_valid,
  output logic         o_ready,
  output sample_word_t o_sample,
  output logic         o_valid,
  input  logic         i_ready
);

  localparam int DEPTH = `SAMPLE_DELAY + 1;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  sample_word_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             active;   // Set once out of reset.
  logic             full;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count == CNT_W'(DEPTH));
  assign o_valid = full;              // Nothing leaves before the line is filled.
  assign pop     = full && i_ready;
  assign o_ready = active && (!full || pop);
  assign push    = i_valid && o_ready;
  assign o_sample = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      active <= 1'b0;
    end else begin
      active <= 1'b1;
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;       // Both or neither.
      endcase
    end
  end

  // Storage.
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_sample;
    end
  end

endmodule

// File: gain/agc_gain_divider.sv
/* AGC gain divider.
   Restoring shift-subtract division of AGC_REF_LEVEL*256 by the magnitude,
   rounded to nearest and saturated to a Q8.8 gain. */
`timescale 1ns/1ps
`include "peak_detector_config.svh"

module agc_gain_divider (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`WIDTH_MAG-1:0] i_magnitude,
  input  logic                  i_valid,
  output logic                  o_ready,
  output logic [15:0]           o_gain,
  output logic                  o_valid,
  input  logic                  i_ready
);

  localparam int QW    = `WIDTH_MAG + 8;   // Quotient width.
  localparam int CNT_W = $clog2(QW);
  localparam logic [QW-1:0] DIVIDEND = QW'(`AGC_REF_LEVEL) << 8;

  logic                  active;
  logic                  busy;
  logic                  done;
  logic [CNT_W-1:0]      cnt;
  logic                  start;
  logic [`WIDTH_MAG-1:0] divisor;
  logic [`WIDTH_MAG-1:0] rem;
  logic [QW-1:0]         quo;
  logic [`WIDTH_MAG:0]   trial;
  logic                  trial_ge;
  logic                  round_up;
  logic [QW:0]           quo_rnd;

  assign o_ready = active && !busy && !done;
  assign start   = i_valid && o_ready;
  assign o_valid = done;

  // One quotient bit per cycle.
  assign trial    = {rem, quo[QW-1]};
  assign trial_ge = (trial >= {1'b0, divisor});

  // Round half up from the final remainder.
  assign round_up = ({rem, 1'b0} >= {1'b0, divisor});
  assign quo_rnd  = {1'b0, quo} + (QW+1)'(round_up);
  assign o_gain   = ((divisor == '0) || (|quo_rnd[QW:16])) ? 16'hffff : quo_rnd[15:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
      busy   <= 1'b0;
      done   <= 1'b0;
      cnt    <= '0;
    end else begin
      active <= 1'b1;
      if (start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == CNT_W'(QW - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;       // Held until taken.
        end
      end
      if (done && i_ready) begin
        done <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      divisor <= i_magnitude;
      quo     <= DIVIDEND;
      rem     <= '0;
    end else if (busy) begin
      rem <= trial_ge ? (trial[`WIDTH_MAG-1:0] - divisor) : trial[`WIDTH_MAG-1:0];
      quo <= {quo[QW-2:0], trial_ge};
    end
  end

endmodule

// File: gain/agc_scaler.sv
/* AGC scaler.
   Two-stage I/Q multiply by a Q8.8 gain with rounding and saturation. */
`timescale 1ns/1ps
`include "peak_detector_config.svh"

module agc_scaler
  import peak_detector_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  sample_word_t i_sample,
  input  logic         i_last,
  input  logic [15:0]  i_gain,
  input  logic         i_valid,
  output logic         o_ready,
  output sample_word_t o_sample,
  output logic         o_last,
  output logic         o_valid,
  input  logic         i_ready
);

  localparam int W  = `WIDTH_SAMPLE;
  localparam int PW = W + 17;         // Signed sample times unsigned gain.
  localparam logic signed [PW:0]  ROUND_HALF = 128;
  localparam logic signed [W-1:0] SAT_MAX = {1'b0, {(W-1){1'b1}}};
  localparam logic signed [W-1:0] SAT_MIN = {1'b1, {(W-1){1'b0}}};

  logic                 en;
  logic signed [16:0]   gain_s;
  logic signed [PW-1:0] s1_prod_i;
  logic signed [PW-1:0] s1_prod_q;
  logic                 s1_valid;
  logic                 s1_last;
  sample_word_t         s2_sample;
  logic                 s2_valid;
  logic                 s2_last;

  // Drop the 8 fraction bits with rounding, then clip to the sample range.
  function automatic logic signed [W-1:0] round_sat(input logic signed [PW-1:0] prod);
    logic signed [PW:0]   rounded;
    logic signed [PW-8:0] shifted;
    rounded = prod + ROUND_HALF;
    shifted = rounded[PW:8];
    if (shifted > SAT_MAX) begin
      return SAT_MAX;
    end else if (shifted < SAT_MIN) begin
      return SAT_MIN;
    end
    return shifted[W-1:0];
  endfunction

  assign en      = !s2_valid || i_ready;   // Whole pipe moves together.
  assign o_ready = en;
  assign gain_s  = $signed({1'b0, i_gain});

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
      s2_valid <= 1'b0;
      s2_last  <= 1'b0;
    end else if (en) begin
      s1_valid <= i_valid;
      s1_last  <= i_valid && i_last;
      s2_valid <= s1_valid;
      s2_last  <= s1_last;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      s1_prod_i      <= i_sample.iq.i * gain_s;
      s1_prod_q      <= i_sample.iq.q * gain_s;
      s2_sample.iq.i <= round_sat(s1_prod_i);
      s2_sample.iq.q <= round_sat(s1_prod_q);
    end
  end

  assign o_sample = s2_sample;
  assign o_last   = s2_last;
  assign o_valid  = s2_valid;

endmodule

// File: peak_detector/peak_search_fsm.sv
/* Preamble peak search.
   Threshold detection, peak tracking and output alignment, with the
   frequency-correction word derived from the phase at the peak. */
`timescale 1ns/1ps
`include "peak_detector_config.svh"

module peak_search_fsm
  import peak_detector_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     i_consume,
  input  logic [`WIDTH_METRIC-1:0] i_metric,
  input  logic [`WIDTH_PHASE-1:0]  i_phase,
  input  logic [15:0]              i_gain,
  input  logic [15:0]              i_threshold,
  output logic                     o_marker,
  output logic [15:0]              o_gain,
  output logic [`WIDTH_PHASE-1:0]  o_phase_corr
);

  localparam int WP         = `WIDTH_PHASE;
  localparam int CNT_W      = $clog2(`SAMPLE_DELAY);
  localparam int ALIGN_BASE = `SAMPLE_DELAY - `PREAMBLE_LEN - 1;

  // round(2^31 * 2 / PREAMBLE_LEN).
  localparam logic [63:0] FACTOR_64 =
    ((64'd1 << WP) + 64'(`PREAMBLE_LEN / 2)) / 64'(`PREAMBLE_LEN);
  localparam logic signed [WP-1:0]   PHASE_FACTOR = FACTOR_64[WP-1:0];
  localparam logic signed [2*WP-1:0] PROD_HALF    = (2*WP)'(1) << (WP - 2);
  localparam logic signed [WP-1:0]   PHASE_MAX    = {1'b0, {(WP-1){1'b1}}};
  localparam logic signed [WP-1:0]   PHASE_MIN    = {1'b1, {(WP-1){1'b0}}};

  search_state_t            state;
  logic [`WIDTH_METRIC-1:0] max_metric;
  logic [`WIDTH_METRIC-1:0] max_metric_87_5;
  logic signed [WP-1:0]     max_phase;
  logic [15:0]              max_gain;
  logic [CNT_W-1:0]         peak_offset;
  logic [CNT_W-1:0]         align_cnt;
  logic                     marker;
  logic signed [WP-1:0]     phase_inc;
  logic signed [2*WP-1:0]   prod_q;
  logic signed [2*WP-1:0]   prod_rnd;
  logic signed [WP-1:0]     phase_next;

  assign max_metric_87_5 = max_metric - (max_metric >> 3);

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= S_WAIT_THRESHOLD;
      max_metric  <= '0;
      max_phase   <= '0;
      max_gain    <= '0;   // Output stays zero until the first peak.
      peak_offset <= '0;
      align_cnt   <= '0;
      marker      <= 1'b0;
    end else if (i_consume) begin
      case (state)
        S_WAIT_THRESHOLD: begin
          marker      <= 1'b0;
          peak_offset <= '0;
          align_cnt   <= '0;
          if (i_metric > i_threshold) begin
            max_metric <= i_metric;
            max_phase  <= i_phase;
            max_gain   <= i_gain;
            state      <= S_TRACK_PEAK;
          end
        end
        S_TRACK_PEAK: begin
          if (i_metric > max_metric) begin   // New maximum.
            max_metric  <= i_metric;
            max_phase   <= i_phase;
            max_gain    <= i_gain;
            peak_offset <= '0;
          end else begin
            peak_offset <= peak_offset + 1'b1;
          end
          if (i_metric < max_metric_87_5) begin
            state <= S_ALIGN_OUTPUT;
          end else if (peak_offset > CNT_W'(`PREAMBLE_LEN)) begin
            state <= S_WAIT_THRESHOLD;         // Too wide to be a preamble.
          end
        end
        S_ALIGN_OUTPUT: begin
          align_cnt <= align_cnt + 1'b1;
          // Marker goes on the delayed sample at the preamble start.
          if (int'(align_cnt) > ALIGN_BASE - int'(peak_offset)) begin
            marker <= 1'b1;
            state  <= S_WAIT_THRESHOLD;
          end
        end
        default: state <= S_WAIT_THRESHOLD;
      endcase
    end
  end

  // Phase correction is -phase * 2 / PREAMBLE_LEN.
  assign phase_inc = -max_phase;

  always_comb begin
    prod_rnd = prod_q + PROD_HALF;
    if (prod_rnd[2*WP-1] != prod_rnd[2*WP-2]) begin
      phase_next = prod_rnd[2*WP-1] ? PHASE_MIN : PHASE_MAX;
    end else begin
      phase_next = prod_rnd[2*WP-2:WP-1];   // Keep bits 62:31.
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_q       <= '0;
      o_phase_corr <= '0;
    end else begin
      prod_q       <= phase_inc * PHASE_FACTOR;
      o_phase_corr <= phase_next;
    end
  end

  assign o_marker = marker;
  assign o_gain   = max_gain;

endmodule

// File: peak_detector/preamble_peak_detector.sv
/* OFDM preamble peak detector.
   Joins the metric, phase, gain and delayed sample streams and emits
   AGC-scaled samples with a preamble marker and a frequency-correction word. */
`timescale 1ns/1ps
`include "peak_detector_config.svh"

module preamble_peak_detector
  import peak_detector_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     i_set_stb,
  input  logic [7:0]               i_set_addr,
  input  logic [31:0]              i_set_data,
  input  logic [`WIDTH_METRIC-1:0] i_metric,
  input  logic                     i_metric_valid,
  output logic                     o_metric_ready,
  input  logic [`WIDTH_PHASE-1:0]  i_phase,
  input  logic                     i_phase_valid,
  output logic                     o_phase_ready,
  input  logic [`WIDTH_MAG-1:0]    i_magnitude,
  input  logic                     i_magnitude_valid,
  output logic                     o_magnitude_ready,
  input  sample_word_t             i_sample,
  input  logic                     i_sample_valid,
  output logic                     o_sample_ready,
  output sample_word_t             o_sample,
  output logic [`WIDTH_PHASE-1:0]  o_phase,
  output logic                     o_last,
  output logic                     o_valid,
  input  logic                     i_ready
);

  logic [15:0]  threshold;
  sample_word_t dly_sample;
  logic         dly_valid;
  logic [15:0]  div_gain;
  logic         div_valid;
  logic         scaler_ready;
  logic         consume;
  logic         marker;
  logic [15:0]  held_gain;

  // All index-aligned words present and room downstream.
  assign consume = dly_valid && i_metric_valid && i_phase_valid && div_valid && scaler_ready;
  assign o_metric_ready = consume;
  assign o_phase_ready  = consume;

  settings_reg u_settings_reg (
    .clk(clk), .reset(reset),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .o_threshold(threshold));

  sample_delay_line u_delay_line (
    .clk(clk), .reset(reset),
    .i_sample(i_sample), .i_valid(i_sample_valid), .o_ready(o_sample_ready),
    .o_sample(dly_sample), .o_valid(dly_valid), .i_ready(consume));

  agc_gain_divider u_gain_divider (
    .clk(clk), .reset(reset),
    .i_magnitude(i_magnitude), .i_valid(i_magnitude_valid), .o_ready(o_magnitude_ready),
    .o_gain(div_gain), .o_valid(div_valid), .i_ready(consume));

  peak_search_fsm u_peak_search (
    .clk(clk), .reset(reset),
    .i_consume(consume), .i_metric(i_metric), .i_phase(i_phase), .i_gain(div_gain),
    .i_threshold(threshold),
    .o_marker(marker), .o_gain(held_gain), .o_phase_corr(o_phase));

  // Delayed sample scaled by the gain held from the last peak.
  agc_scaler u_scaler (
    .clk(clk), .reset(reset),
    .i_sample(dly_sample), .i_last(marker), .i_gain(held_gain),
    .i_valid(consume), .o_ready(scaler_ready),
    .o_sample(o_sample), .o_last(o_last), .o_valid(o_valid), .i_ready(i_ready));

endmodule

// File: verification/peak_detector_assertions.sv
/* Peak detector assertions.
   Output handshake, reset values and search FSM transitions. */
`timescale 1ns/1ps

module peak_detector_assertions
  import peak_detector_pkg::*;
(
  input logic          clk,
  input logic          reset,
  input logic          i_out_valid,
  input logic          i_out_ready,
  input sample_word_t  i_out_sample,
  input logic          i_out_last,
  input logic          i_metric_ready,
  input logic          i_mag_ready,
  input logic          i_sample_ready,
  input search_state_t i_state
);

  // A stalled output word stays put.
  assert property (@(posedge clk) disable iff (reset)
    i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out_sample) && $stable(i_out_last))
    else $error("output word changed while stalled");

  assert property (@(posedge clk)
    reset |=> !i_out_valid && !i_metric_ready && !i_mag_ready && !i_sample_ready)
    else $error("output or ready high during reset");

  // Align is reached only through the track state.
  assert property (@(posedge clk) disable iff (reset)
    i_state == S_WAIT_THRESHOLD |=> i_state != S_ALIGN_OUTPUT)
    else $error("search FSM went from wait straight to align");

  // Align ends only in the wait state.
  assert property (@(posedge clk) disable iff (reset)
    i_state == S_ALIGN_OUTPUT |=> i_state inside {S_ALIGN_OUTPUT, S_WAIT_THRESHOLD})
    else $error("search FSM left align for a state other than wait");

endmodule

bind preamble_peak_detector peak_detector_assertions u_assertions (
  .clk(clk), .reset(reset),
  .i_out_valid(o_valid), .i_out_ready(i_ready),
  .i_out_sample(o_sample), .i_out_last(o_last),
  .i_metric_ready(o_metric_ready), .i_mag_ready(o_magnitude_ready),
  .i_sample_ready(o_sample_ready), .i_state(u_peak_search.state));

// File: verification/peak_detector_tb.sv
/* Preamble peak detector testbench.
   Random streams with inserted peaks, checked against a reference model. */
`timescale 1ns/1ps
`include "peak_detector_config.svh"

module peak_detector_tb
  import peak_detector_pkg::*;
();

  localparam int N      = 600;
  localparam int NOUT   = N - `SAMPLE_DELAY;
  localparam int LIMIT  = N * (`WIDTH_MAG + 8) * 4;
  localparam int THRESH = 2000;

  logic clk;
  logic reset;
  logic i_set_stb;
  logic [7:0] i_set_addr;
  logic [31:0] i_set_data;
  logic [15:0] i_metric;
  logic i_metric_valid;
  logic o_metric_ready;
  logic [31:0] i_phase;
  logic i_phase_valid;
  logic o_phase_ready;
  logic [15:0] i_magnitude;
  logic i_magnitude_valid;
  logic o_magnitude_ready;
  sample_word_t i_sample;
  logic i_sample_valid;
  logic o_sample_ready;
  sample_word_t o_sample;
  logic [31:0] o_phase;
  logic o_last;
  logic o_valid;
  logic i_ready;

  integer seed = 32'hab9b_5362;
  int cycles = 0;

  logic [15:0]  metric_mem [N];
  logic [31:0]  phase_mem [N];
  logic [15:0]  mag_mem [N];
  sample_word_t samp_mem [N];
  sample_word_t exp_sample [NOUT];
  logic         exp_last [NOUT];
  logic [31:0]  exp_phase [NOUT];
  int model_markers;

  int m_idx = 0, p_idx = 0, g_idx = 0, s_idx = 0, out_idx = 0;
  logic m_fire = 0, p_fire = 0, g_fire = 0, s_fire = 0, o_fire = 0;
  sample_word_t got_sample;
  logic got_last;
  logic [31:0] got_phase;

  preamble_peak_detector DUT (.*);

  always #2 clk = ~clk;

  // Run length guard.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles, %0d of %0d outputs seen", cycles, out_idx, NOUT);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

  function automatic bit coin(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // Q8.8 gain as reference level over magnitude rounded half up.
  function automatic logic [15:0] gain_from_magnitude(input logic [15:0] mag);
    longint q;
    longint r;
    if (mag == 0) return 16'hffff;
    q = (longint'(`AGC_REF_LEVEL) * 256) / mag;
    r = (longint'(`AGC_REF_LEVEL) * 256) % mag;
    if (2 * r >= mag) q = q + 1;
    if (q > 65535) return 16'hffff;
    return q[15:0];
  endfunction

  function automatic logic [15:0] scale_component(input logic signed [15:0] x,
                                                  input logic [15:0] g);
    longint p;
    p = (longint'(x) * longint'(g) + 128) >>> 8;
    if (p > 32767) return 16'h7fff;
    if (p < -32768) return 16'h8000;
    return p[15:0];
  endfunction

  function automatic sample_word_t scale_sample(input sample_word_t s, input logic [15:0] g);
    sample_word_t r;
    r.iq.i = scale_component(s.iq.i, g);
    r.iq.q = scale_component(s.iq.q, g);
    return r;
  endfunction

  // Bits 62:31 of the rounded product of the negated phase and 2/PREAMBLE_LEN.
  function automatic logic [31:0] phase_correction(input logic [31:0] ph);
    logic signed [31:0] neg;
    longint f;
    longint p;
    neg = -$signed(ph);
    f = ((longint'(1) <<< 32) + `PREAMBLE_LEN / 2) / `PREAMBLE_LEN;
    p = longint'(neg) * f + (longint'(1) <<< 30);
    if (p >= (longint'(1) <<< 62)) return 32'h7fff_ffff;
    if (p < -(longint'(1) <<< 62)) return 32'h8000_0000;
    return p[62:31];
  endfunction

  task automatic make_stimulus();
    logic [31:0] r;
    for (int k = 0; k < N; k++) begin
      metric_mem[k] = 16'($unsigned($random(seed)) % 1800);   // Noise below threshold.
      phase_mem[k]  = $random(seed);
      r = $random(seed);
      mag_mem[k] = (r % 40 == 0) ? 16'd0 : 16'(8 + r % 3000);
      samp_mem[k].raw = $random(seed);
    end
    for (int d = -4; d <= 4; d++) metric_mem[150 + d] = 16'(20000 - (d < 0 ? -d : d) * 3000);
    // Flat top just long enough to time out the track state.
    for (int j = 0; j < `PREAMBLE_LEN + 3; j++) metric_mem[300 + j] = 16'd30000;
    for (int d = -5; d <= 5; d++) metric_mem[420 + d] = 16'(12000 - (d < 0 ? -d : d) * 1500);
  endtask

  task automatic run_reference_model();
    search_state_t st;
    int mx, off, cnt, m, lim;
    logic [31:0] ph;
    logic [15:0] g, gk;
    logic mk;
    st = S_WAIT_THRESHOLD;
    mx = 0;
    off = 0;
    cnt = 0;
    ph = '0;
    g = '0;
    mk = 1'b0;
    model_markers = 0;
    for (int k = 0; k < NOUT; k++) begin
      exp_sample[k] = scale_sample(samp_mem[k], g);
      exp_last[k]   = mk;
      exp_phase[k]  = phase_correction(ph);
      if (mk) model_markers++;
      m  = metric_mem[k];
      gk = gain_from_magnitude(mag_mem[k]);
      case (st)
        S_WAIT_THRESHOLD: begin
          mk = 1'b0;
          off = 0;
          cnt = 0;
          if (m > THRESH) begin
            mx = m;
            ph = phase_mem[k];
            g = gk;
            st = S_TRACK_PEAK;
          end
        end
        S_TRACK_PEAK: begin
          lim = mx - (mx >> 3);
          if (m < lim) st = S_ALIGN_OUTPUT;
          else if (off > `PREAMBLE_LEN) st = S_WAIT_THRESHOLD;
          if (m > mx) begin
            mx = m;
            ph = phase_mem[k];
            g = gk;
            off = 0;
          end else begin
            off = off + 1;
          end
        end
        default: begin
          if (cnt > `SAMPLE_DELAY - `PREAMBLE_LEN - off - 1) begin
            mk = 1'b1;
            st = S_WAIT_THRESHOLD;
          end
          cnt = cnt + 1;
        end
      endcase
    end
  endtask

  task automatic stop_on_error();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_sample(input sample_word_t got, input sample_word_t exp);
    if (got !== exp) begin
      $display("** Error: o_sample = %h, expected %h (output %0d)", got, exp, out_idx);
      stop_on_error();
    end
  endtask

  task automatic check_phase(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: o_phase = %h, expected %h (output %0d)", got, exp, out_idx);
      stop_on_error();
    end
  endtask

  task automatic check_marker(input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: o_last = %h, expected %h (output %0d)", got, exp, out_idx);
      stop_on_error();
    end
  endtask

  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(posedge clk);
    #1;
    i_set_stb = 1'b0;
  endtask

  // Retire handshakes, check the output, drive the next inputs and sample.
  task automatic step_cycle();
    @(posedge clk);
    #1;
    if (m_fire) m_idx++;
    if (p_fire) p_idx++;
    if (g_fire) g_idx++;
    if (s_fire) s_idx++;
    if (o_fire) begin
      if (out_idx >= NOUT) begin
        $display("More output words than input samples allow");
        stop_on_error();
      end
      check_sample(got_sample, exp_sample[out_idx]);
      check_marker(got_last, exp_last[out_idx]);
      if (exp_last[out_idx]) check_phase(got_phase, exp_phase[out_idx]);
      out_idx++;
    end
    if (!i_metric_valid || m_fire) i_metric_valid = (m_idx < N) && coin(70);
    if (!i_phase_valid || p_fire) i_phase_valid = (p_idx < N) && coin(70);
    if (!i_magnitude_valid || g_fire) i_magnitude_valid = (g_idx < N) && coin(60);
    if (!i_sample_valid || s_fire) i_sample_valid = (s_idx < N) && coin(70);
    if (m_idx < N) i_metric = metric_mem[m_idx];
    if (p_idx < N) i_phase = phase_mem[p_idx];
    if (g_idx < N) i_magnitude = mag_mem[g_idx];
    if (s_idx < N) i_sample = samp_mem[s_idx];
    i_ready = coin(75);
    #2;
    m_fire = i_metric_valid && o_metric_ready;
    p_fire = i_phase_valid && o_phase_ready;
    g_fire = i_magnitude_valid && o_magnitude_ready;
    s_fire = i_sample_valid && o_sample_ready;
    o_fire = o_valid && i_ready;
    got_sample = o_sample;
    got_last   = o_last;
    got_phase  = o_phase;
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    i_set_stb = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_metric = '0;
    i_metric_valid = 1'b0;
    i_phase = '0;
    i_phase_valid = 1'b0;
    i_magnitude = '0;
    i_magnitude_valid = 1'b0;
    i_sample = '0;
    i_sample_valid = 1'b0;
    i_ready = 1'b0;
    make_stimulus();
    run_reference_model();
    if (model_markers != 2) begin
      $display("Stimulus does not give the two expected preamble markers");
      stop_on_error();
    end
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    write_setting(8'(`SR_THRESHOLD), 32'(THRESH));
    write_setting(8'd3, 32'd10);          // Other addresses are ignored.
    write_setting(8'h85, 32'd0);
    while (out_idx < NOUT) step_cycle();
    repeat (200) step_cycle();            // Nothing more may come out.
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: peak_detector.f
+incdir+common
common/peak_detector_pkg.sv
logic/settings_reg.sv
logic/sample_delay_line.sv
gain/agc_gain_divider.sv
gain/agc_scaler.sv
peak_detector/peak_search_fsm.sv
peak_detector/preamble_peak_detector.sv
verification/peak_detector_assertions.sv
verification/peak_detector_tb.sv

// File: Makefile
# Verilator build and run of the preamble peak detector testbench.

VERILATOR ?= verilator
TOP       ?= peak_detector_tb
FILELIST  ?= peak_detector.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
